//--- adapter_cfg.svh
// Widths and memory-island window for the cluster adapter
// Window end is exclusive and both bounds are byte addresses
// Wide data must be exactly two narrow beats wide
`ifndef ADAPTER_CFG_SVH
`define ADAPTER_CFG_SVH

// Bus widths
`define ADAPTER_ADDR_W        32
`define ADAPTER_WIDE_DATA_W   64
`define ADAPTER_NARROW_DATA_W 32

// ID widths on the cluster and SoC side
`define ADAPTER_CLU_ID_W      6
`define ADAPTER_SOC_ID_W      4

// Memory-island window
`define ADAPTER_MEMISL_START  32'h2000_0000
`define ADAPTER_MEMISL_END    32'h2010_0000

// Byte distance between the two narrow beats
`define ADAPTER_NARROW_STEP   4

`endif

//--- adapter_pkg.sv
// Shared types for the cluster adapter
// Narrow beat 0 is the low half of a wide data word
`include "adapter_cfg.svh"

package adapter_pkg;

  typedef logic [`ADAPTER_ADDR_W-1:0]        addr_t;
  typedef logic [`ADAPTER_CLU_ID_W-1:0]      clu_id_t;
  typedef logic [`ADAPTER_SOC_ID_W-1:0]      soc_id_t;
  typedef logic [`ADAPTER_NARROW_DATA_W-1:0] narrow_beat_t;

  // One wide word, seen whole or as its narrow beats
  typedef union packed {
    logic [`ADAPTER_WIDE_DATA_W-1:0] word;
    narrow_beat_t [`ADAPTER_WIDE_DATA_W/`ADAPTER_NARROW_DATA_W-1:0] beats;
  } wide_data_u;

  // Where a wide request leaves the adapter
  typedef enum logic {
    ROUTE_MEMISL = 1'b0,
    ROUTE_NARROW = 1'b1
  } route_e;

endpackage

//--- cluster_adapter_asserts.sv
// Bound checker for bypass routing, narrow request spacing and narrow last
// Treats out-of-window and bypass requests as narrow-bound
`timescale 1ns/100ps
`include "adapter_cfg.svh"

module cluster_adapter_asserts (
  input logic                       soc_clk_i,
  input logic                       arst_n_i,
  input logic                       bypass_mode_i,
  input logic                       req_valid_i,
  input logic [`ADAPTER_ADDR_W-1:0] req_addr_i,
  input logic                       wide_valid_i,
  input logic                       narrow_valid_i,
  input logic                       narrow_last_i
);

  int   fail_count = 0;
  logic narrow_req;

  assign narrow_req = req_valid_i && (bypass_mode_i ||
                      (req_addr_i < `ADAPTER_MEMISL_START) ||
                      (req_addr_i >= `ADAPTER_MEMISL_END));

  // Bypass requests never reach the wide port
  bypass_no_wide_a: assert property (@(posedge soc_clk_i) disable iff (!arst_n_i)
    (req_valid_i && bypass_mode_i) |-> ##2 !wide_valid_i)
    else begin
      $error("Wide port fired two cycles after a bypass request");
      fail_count++;
    end

  // Split holds one request, so narrow requests need a gap
  narrow_spacing_a: assert property (@(posedge soc_clk_i) disable iff (!arst_n_i)
    narrow_req |=> !narrow_req)
    else begin
      $error("Two narrow-bound requests arrived on consecutive cycles");
      fail_count++;
    end

  last_with_valid_a: assert property (@(posedge soc_clk_i) disable iff (!arst_n_i)
    narrow_last_i |-> narrow_valid_i)
    else begin
      $error("narrow_last_o was high without narrow_valid_o");
      fail_count++;
    end

endmodule

bind cluster_adapter_top cluster_adapter_asserts u_asserts (
  .soc_clk_i     (soc_clk_i),
  .arst_n_i      (arst_n_i),
  .bypass_mode_i (bypass_mode_i),
  .req_valid_i   (req_valid_i),
  .req_addr_i    (req_addr_i),
  .wide_valid_i  (wide_valid_o),
  .narrow_valid_i(narrow_valid_o),
  .narrow_last_i (narrow_last_o)
);

//--- cluster_adapter_top.sv
// Cluster wide-request adapter, request issue only and no responses
// Wide port output 2 cycles after a request, narrow beats after 3 and 4
// Narrow-bound requests must be at least 2 cycles apart
`timescale 1ns/100ps
`include "adapter_cfg.svh"

module cluster_adapter_top (
  input  logic                            soc_clk_i,
  input  logic                            arst_n_i,
  input  logic                            bypass_mode_i,
  // From cluster
  input  logic                            req_valid_i,
  input  logic                            req_write_i,
  input  adapter_pkg::addr_t              req_addr_i,
  input  adapter_pkg::clu_id_t            req_id_i,
  input  adapter_pkg::wide_data_u         req_data_i,
  // Memory island
  output logic                            wide_valid_o,
  output logic                            wide_write_o,
  output adapter_pkg::addr_t              wide_addr_o,
  output adapter_pkg::soc_id_t            wide_id_o,
  output logic [`ADAPTER_WIDE_DATA_W-1:0] wide_data_o,
  // Narrow SoC interconnect
  output logic                            narrow_valid_o,
  output logic                            narrow_write_o,
  output adapter_pkg::addr_t              narrow_addr_o,
  output adapter_pkg::soc_id_t            narrow_id_o,
  output adapter_pkg::narrow_beat_t       narrow_data_o,
  output logic                            narrow_last_o
);

  import adapter_pkg::*;

  logic         dec_valid;
  logic         dec_write;
  addr_t        dec_addr;
  clu_id_t      dec_id;
  wide_data_u   dec_data;
  route_e       dec_route;

  logic         beat_valid;
  logic         beat_write;
  addr_t        beat_addr;
  clu_id_t      beat_id;
  narrow_beat_t beat_data;
  logic         beat_last;

  wide_addr_decode i_decode (
    .soc_clk_i    (soc_clk_i),
    .arst_n_i     (arst_n_i),
    .bypass_mode_i(bypass_mode_i),
    .req_valid_i  (req_valid_i),
    .req_write_i  (req_write_i),
    .req_addr_i   (req_addr_i),
    .req_id_i     (req_id_i),
    .req_data_i   (req_data_i),
    .dec_valid_o  (dec_valid),
    .dec_write_o  (dec_write),
    .dec_addr_o   (dec_addr),
    .dec_id_o     (dec_id),
    .dec_data_o   (dec_data),
    .dec_route_o  (dec_route)
  );

  wide_to_narrow_split i_split (
    .soc_clk_i   (soc_clk_i),
    .arst_n_i    (arst_n_i),
    .dec_valid_i (dec_valid),
    .dec_route_i (dec_route),
    .dec_write_i (dec_write),
    .dec_addr_i  (dec_addr),
    .dec_id_i    (dec_id),
    .dec_data_i  (dec_data),
    .beat_valid_o(beat_valid),
    .beat_write_o(beat_write),
    .beat_addr_o (beat_addr),
    .beat_id_o   (beat_id),
    .beat_data_o (beat_data),
    .beat_last_o (beat_last)
  );

  soc_port_stage i_port_stage (
    .soc_clk_i     (soc_clk_i),
    .arst_n_i      (arst_n_i),
    .dec_valid_i   (dec_valid),
    .dec_route_i   (dec_route),
    .dec_write_i   (dec_write),
    .dec_addr_i    (dec_addr),
    .dec_id_i      (dec_id),
    .dec_data_i    (dec_data),
    .beat_valid_i  (beat_valid),
    .beat_write_i  (beat_write),
    .beat_addr_i   (beat_addr),
    .beat_id_i     (beat_id),
    .beat_data_i   (beat_data),
    .beat_last_i   (beat_last),
    .wide_valid_o  (wide_valid_o),
    .wide_write_o  (wide_write_o),
    .wide_addr_o   (wide_addr_o),
    .wide_id_o     (wide_id_o),
    .wide_data_o   (wide_data_o),
    .narrow_valid_o(narrow_valid_o),
    .narrow_write_o(narrow_write_o),
    .narrow_addr_o (narrow_addr_o),
    .narrow_id_o   (narrow_id_o),
    .narrow_data_o (narrow_data_o),
    .narrow_last_o (narrow_last_o)
  );

endmodule

//--- filelist.f
+incdir+.
adapter_pkg.sv
wide_addr_decode.sv
wide_to_narrow_split.sv
soc_port_stage.sv
cluster_adapter_top.sv
cluster_adapter_asserts.sv
tb_clock_gen.sv
tb_cluster_adapter.sv

//--- soc_port_stage.sv
// Output registers for the wide and narrow SoC ports
// Cluster IDs are cut to their low bits, so distinct IDs may collide
`timescale 1ns/100ps
`include "adapter_cfg.svh"

module soc_port_stage (
  input  logic                             soc_clk_i,
  input  logic                             arst_n_i,
  // Decoded request, memory-island route only
  input  logic                             dec_valid_i,
  input  adapter_pkg::route_e              dec_route_i,
  input  logic                             dec_write_i,
  input  adapter_pkg::addr_t               dec_addr_i,
  input  adapter_pkg::clu_id_t             dec_id_i,
  input  adapter_pkg::wide_data_u          dec_data_i,
  // Narrow beats from the width converter
  input  logic                             beat_valid_i,
  input  logic                             beat_write_i,
  input  adapter_pkg::addr_t               beat_addr_i,
  input  adapter_pkg::clu_id_t             beat_id_i,
  input  adapter_pkg::narrow_beat_t        beat_data_i,
  input  logic                             beat_last_i,
  // Wide SoC port
  output logic                             wide_valid_o,
  output logic                             wide_write_o,
  output adapter_pkg::addr_t               wide_addr_o,
  output adapter_pkg::soc_id_t             wide_id_o,
  output logic [`ADAPTER_WIDE_DATA_W-1:0]  wide_data_o,
  // Narrow SoC port
  output logic                             narrow_valid_o,
  output logic                             narrow_write_o,
  output adapter_pkg::addr_t               narrow_addr_o,
  output adapter_pkg::soc_id_t             narrow_id_o,
  output adapter_pkg::narrow_beat_t        narrow_data_o,
  output logic                             narrow_last_o
);

  import adapter_pkg::*;

  logic memisl_sel;

  assign memisl_sel = dec_valid_i && (dec_route_i == ROUTE_MEMISL);

  always_ff @(posedge soc_clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      wide_valid_o   <= 1'b0;
      narrow_valid_o <= 1'b0;
      narrow_last_o  <= 1'b0;
    end else begin
      wide_valid_o   <= memisl_sel;
      narrow_valid_o <= beat_valid_i;
      narrow_last_o  <= beat_last_i;
    end
  end

  // Memory island sees offsets from its own base
  always_ff @(posedge soc_clk_i) begin
    if (memisl_sel) begin
      wide_write_o <= dec_write_i;
      wide_addr_o  <= dec_addr_i - addr_t'(`ADAPTER_MEMISL_START);
      wide_id_o    <= dec_id_i[`ADAPTER_SOC_ID_W-1:0];
      wide_data_o  <= dec_data_i.word;
    end
  end

  always_ff @(posedge soc_clk_i) begin
    if (beat_valid_i) begin
      narrow_write_o <= beat_write_i;
      narrow_addr_o  <= beat_addr_i;
      narrow_id_o    <= beat_id_i[`ADAPTER_SOC_ID_W-1:0];
      narrow_data_o  <= beat_data_i;
    end
  end

endmodule

//--- tb_clock_gen.sv
// Testbench clock of 10 ns and an active-low reset held for 2 cycles
// Reset is released 1 ns after the second rising edge
`timescale 1ns/100ps

module tb_clock_gen (
  output logic clk_o,
  output logic arst_n_o
);

  localparam int HALF_PERIOD_NS = 5;
  localparam int RESET_CYCLES   = 2;

  initial begin
    clk_o = 1'b0;
    forever #(HALF_PERIOD_NS) clk_o = ~clk_o;
  end

  initial begin
    arst_n_o = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk_o);
    #1;
    arst_n_o = 1'b1;
  end

endmodule

//--- tb_cluster_adapter.sv
// Directed tests for the cluster adapter against a cycle-stamped reference model
// Narrow-bound requests are always driven at least 2 cycles apart
`timescale 1ns/100ps
`include "adapter_cfg.svh"

module tb_cluster_adapter;

  localparam int CLK_PERIOD_NS = 10;
  localparam int DRIVE_DELAY   = 1;
  localparam int NUM_BURST     = 4;
  localparam int NUM_ALT       = 8;
  // Three single requests, burst, alternating stream and four window edges
  localparam int NUM_REQS      = 3 + NUM_BURST + NUM_ALT + 4;
  localparam int WATCHDOG_NS   = (NUM_REQS + 10) * CLK_PERIOD_NS * 4;

  logic        clk;
  logic        arst_n;
  logic        bypass_mode;
  logic        req_valid;
  logic        req_write;
  logic [31:0] req_addr;
  logic [5:0]  req_id;
  logic [63:0] req_data;
  logic        wide_valid;
  logic        wide_write;
  logic [31:0] wide_addr;
  logic [3:0]  wide_id;
  logic [63:0] wide_data;
  logic        narrow_valid;
  logic        narrow_write;
  logic [31:0] narrow_addr;
  logic [3:0]  narrow_id;
  logic [31:0] narrow_data;
  logic        narrow_last;

  int     cyc_count = 0;
  logic   mon_en    = 1'b0;
  integer seed      = 32'h55421c41;
  // Entry is {cycle, write, id, addr, data}
  logic [132:0] wide_exp[$];
  // Entry is {cycle, last, write, id, addr, data}
  logic [101:0] narrow_exp[$];

  tb_clock_gen clk_gen0 (.clk_o(clk), .arst_n_o(arst_n));

  cluster_adapter_top dut0 (
    .soc_clk_i(clk), .arst_n_i(arst_n), .bypass_mode_i(bypass_mode),
    .req_valid_i(req_valid), .req_write_i(req_write), .req_addr_i(req_addr),
    .req_id_i(req_id), .req_data_i(req_data),
    .wide_valid_o(wide_valid), .wide_write_o(wide_write), .wide_addr_o(wide_addr),
    .wide_id_o(wide_id), .wide_data_o(wide_data),
    .narrow_valid_o(narrow_valid), .narrow_write_o(narrow_write),
    .narrow_addr_o(narrow_addr), .narrow_id_o(narrow_id),
    .narrow_data_o(narrow_data), .narrow_last_o(narrow_last)
  );

  task automatic check_value(input logic [63:0] actual, input logic [63:0] expected,
                             input string what);
    if (actual !== expected) begin
      $display("CHECK FAILED at time %0t: %s is %h, expected %h", $time, what, actual, expected);
      $display("Simulation failed");
      $fatal(1, "Mismatch on %s", what);
    end
  endtask

  // Outputs are compared at the falling edge, half a cycle after they change
  task automatic check_outputs();
    logic         exp_wv;
    logic         exp_nv;
    logic [132:0] w;
    logic [101:0] n;
    w = '0;
    n = '0;
    if (wide_exp.size() > 0) w = wide_exp[0];
    if (narrow_exp.size() > 0) n = narrow_exp[0];
    exp_wv = (wide_exp.size() > 0) && (w[132:101] == cyc_count);
    exp_nv = (narrow_exp.size() > 0) && (n[101:70] == cyc_count);
    check_value(wide_valid, exp_wv, "wide_valid_o");
    check_value(narrow_valid, exp_nv, "narrow_valid_o");
    check_value(narrow_last, exp_nv && n[69], "narrow_last_o");
    if (exp_wv) begin
      check_value(wide_write, w[100], "wide_write_o");
      check_value(wide_id, w[99:96], "wide_id_o");
      check_value(wide_addr, w[95:64], "wide_addr_o");
      check_value(wide_data, w[63:0], "wide_data_o");
      void'(wide_exp.pop_front());
    end
    if (exp_nv) begin
      check_value(narrow_write, n[68], "narrow_write_o");
      check_value(narrow_id, n[67:64], "narrow_id_o");
      check_value(narrow_addr, n[63:32], "narrow_addr_o");
      check_value(narrow_data, n[31:0], "narrow_data_o");
      void'(narrow_exp.pop_front());
    end
  endtask

  always @(negedge clk) begin
    cyc_count = cyc_count + 1;
    if (mon_en) check_outputs();
  end

  // Drives one request and predicts where and when it leaves the DUT
  task automatic send_request(input logic write, input logic [31:0] addr,
                              input logic [5:0] id, input logic [63:0] data);
    int req_cyc;
    @(posedge clk);
    #(DRIVE_DELAY);
    req_valid = 1'b1;
    req_write = write;
    req_addr  = addr;
    req_id    = id;
    req_data  = data;
    // The coming falling edge counts the cycle in which the request is high
    req_cyc = cyc_count + 1;
    if (addr >= `ADAPTER_MEMISL_START && addr < `ADAPTER_MEMISL_END && !bypass_mode) begin
      wide_exp.push_back({req_cyc + 2, write, id[3:0], addr - `ADAPTER_MEMISL_START, data});
    end else begin
      narrow_exp.push_back({req_cyc + 3, 1'b0, write, id[3:0], addr, data[31:0]});
      narrow_exp.push_back({req_cyc + 4, 1'b1, write, id[3:0],
                            addr + `ADAPTER_NARROW_STEP, data[63:32]});
    end
  endtask

  task automatic idle_cycle();
    @(posedge clk);
    #(DRIVE_DELAY);
    req_valid = 1'b0;
  endtask

  // Waits until every predicted output has been seen, bounded by the watchdog
  task automatic drain_outputs();
    idle_cycle();
    while (wide_exp.size() != 0 || narrow_exp.size() != 0) idle_cycle();
    idle_cycle();
  endtask

  function automatic logic [63:0] rand_data();
    logic [31:0] lo;
    logic [31:0] hi;
    lo = $random(seed);
    hi = $random(seed);
    return {hi, lo};
  endfunction

  function automatic logic [31:0] rand_addr(input logic in_window);
    logic [31:0] r;
    r = $random(seed);
    if (in_window) return `ADAPTER_MEMISL_START + (r & 32'h000F_FFFC);
    return 32'h8000_0000 | (r & 32'h0FFF_FFFC);
  endfunction

  task automatic test_reset_idle();
    check_value(wide_valid, 1'b0, "wide_valid_o after reset");
    check_value(narrow_valid, 1'b0, "narrow_valid_o after reset");
    check_value(narrow_last, 1'b0, "narrow_last_o after reset");
    repeat (5) idle_cycle();
  endtask

  task automatic test_memisl_single();
    send_request(1'b1, 32'h2000_1230, 6'h2b, 64'h0123_4567_89ab_cdef);
    drain_outputs();
  endtask

  task automatic test_narrow_single();
    send_request(1'b0, 32'h4000_0100, 6'h15, 64'hfeed_beef_cafe_f00d);
    drain_outputs();
  endtask

  task automatic test_bypass();
    bypass_mode = 1'b1;
    send_request(1'b1, 32'h2000_0040, 6'h3f, rand_data());
    drain_outputs();
    bypass_mode = 1'b0;
  endtask

  // Memory-island burst, then narrow and memory-island requests interleaved
  task automatic test_mixed_stream();
    logic [31:0] r;
    for (int i = 0; i < NUM_BURST; i++) begin
      r = $random(seed);
      send_request(r[0], rand_addr(1'b1), r[13:8], rand_data());
    end
    for (int i = 0; i < NUM_ALT; i++) begin
      r = $random(seed);
      send_request(r[0], rand_addr(i % 2 == 1), r[13:8], rand_data());
    end
    drain_outputs();
  endtask

  task automatic test_window_edges();
    send_request(1'b0, `ADAPTER_MEMISL_START, 6'h01, rand_data());
    send_request(1'b1, `ADAPTER_MEMISL_END, 6'h12, rand_data());
    send_request(1'b0, `ADAPTER_MEMISL_END - 1, 6'h23, rand_data());
    send_request(1'b1, `ADAPTER_MEMISL_START - 1, 6'h34, rand_data());
    drain_outputs();
  endtask

  initial begin
    #(WATCHDOG_NS);
    $display("Timeout: the tests did not finish within %0d ns", WATCHDOG_NS);
    $display("Simulation failed");
    $fatal(1, "Watchdog expired");
  end

  initial begin
    bypass_mode = 1'b0;
    req_valid   = 1'b0;
    req_write   = 1'b0;
    req_addr    = '0;
    req_id      = '0;
    req_data    = '0;
    wait (arst_n === 1'b1);
    mon_en = 1'b1;
    test_reset_idle();
    test_memisl_single();
    test_narrow_single();
    test_bypass();
    test_mixed_stream();
    test_window_edges();
    if (dut0.u_asserts.fail_count == 0) begin
      $display("Simulation passed");
    end else begin
      $display("The bound assertion checker reported %0d failures",
               dut0.u_asserts.fail_count);
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

//--- wide_addr_decode.sv
// Request decode stage with one cycle of latency
// Requests are one-cycle strobes and cannot be stalled
`timescale 1ns/100ps
`include "adapter_cfg.svh"

module wide_addr_decode (
  input  logic                    soc_clk_i,
  input  logic                    arst_n_i,
  input  logic                    bypass_mode_i,
  // Incoming wide request
  input  logic                    req_valid_i,
  input  logic                    req_write_i,
  input  adapter_pkg::addr_t      req_addr_i,
  input  adapter_pkg::clu_id_t    req_id_i,
  input  adapter_pkg::wide_data_u req_data_i,
  // Registered request with its route
  output logic                    dec_valid_o,
  output logic                    dec_write_o,
  output adapter_pkg::addr_t      dec_addr_o,
  output adapter_pkg::clu_id_t    dec_id_o,
  output adapter_pkg::wide_data_u dec_data_o,
  output adapter_pkg::route_e     dec_route_o
);

  import adapter_pkg::*;

  logic   in_window;
  route_e route_d;

  // Start is inclusive, end is exclusive
  assign in_window = (req_addr_i >= addr_t'(`ADAPTER_MEMISL_START)) &&
                     (req_addr_i <  addr_t'(`ADAPTER_MEMISL_END));

  // Bypass forces every request onto the narrow port
  assign route_d = (in_window && !bypass_mode_i) ? ROUTE_MEMISL : ROUTE_NARROW;

  always_ff @(posedge soc_clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      dec_valid_o <= 1'b0;
    end else begin
      dec_valid_o <= req_valid_i;
    end
  end

  // Payload only moves with a valid request
  always_ff @(posedge soc_clk_i) begin
    if (req_valid_i) begin
      dec_write_o     <= req_write_i;
      dec_addr_o      <= req_addr_i;
      dec_id_o        <= req_id_i;
      dec_data_o.word <= req_data_i.word;
      dec_route_o     <= route_d;
    end
  end

endmodule

//--- wide_to_narrow_split.sv
// Wide-to-narrow width converter for narrow-routed requests
// Holds one request only, so narrow requests must be two cycles apart
// Beat 0 carries the low data half, beat 1 the high half and last
`timescale 1ns/100ps
`include "adapter_cfg.svh"

module wide_to_narrow_split (
  input  logic                      soc_clk_i,
  input  logic                      arst_n_i,
  // Decoded request
  input  logic                      dec_valid_i,
  input  adapter_pkg::route_e       dec_route_i,
  input  logic                      dec_write_i,
  input  adapter_pkg::addr_t        dec_addr_i,
  input  adapter_pkg::clu_id_t      dec_id_i,
  input  adapter_pkg::wide_data_u   dec_data_i,
  // Narrow beat stream
  output logic                      beat_valid_o,
  output logic                      beat_write_o,
  output adapter_pkg::addr_t        beat_addr_o,
  output adapter_pkg::clu_id_t      beat_id_o,
  output adapter_pkg::narrow_beat_t beat_data_o,
  output logic                      beat_last_o
);

  import adapter_pkg::*;

  logic       load;
  logic       hold_valid_q;
  // Index of the beat currently on the output
  logic       beat_cnt_q;
  logic       hold_write_q;
  addr_t      hold_addr_q;
  clu_id_t    hold_id_q;
  wide_data_u hold_data_q;

  assign load = dec_valid_i && (dec_route_i == ROUTE_NARROW);

  always_ff @(posedge soc_clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      hold_valid_q <= 1'b0;
      beat_cnt_q   <= 1'b0;
    end else if (load) begin
      // A new request may replace the one that is sending its last beat
      hold_valid_q <= 1'b1;
      beat_cnt_q   <= 1'b0;
    end else if (hold_valid_q) begin
      if (beat_cnt_q) begin
        hold_valid_q <= 1'b0;
        beat_cnt_q   <= 1'b0;
      end else begin
        beat_cnt_q <= 1'b1;
      end
    end
  end

  always_ff @(posedge soc_clk_i) begin
    if (load) begin
      hold_write_q <= dec_write_i;
      hold_addr_q  <= dec_addr_i;
      hold_id_q    <= dec_id_i;
      hold_data_q  <= dec_data_i;
    end
  end

  assign beat_valid_o = hold_valid_q;
  assign beat_write_o = hold_write_q;
  assign beat_id_o    = hold_id_q;

  // Second beat goes to the next narrow word
  assign beat_addr_o  = beat_cnt_q ? hold_addr_q + addr_t'(`ADAPTER_NARROW_STEP)
                                   : hold_addr_q;
  assign beat_data_o  = hold_data_q.beats[beat_cnt_q];
  // Counter only reaches beat 1 while a request is held
  assign beat_last_o  = beat_cnt_q;

endmodule
